// ==== tb.f ====
+incdir+bench
rtl/tnt_data_pkg.sv
rtl/tnt_cmd_pkg.sv
rtl/taint_decode.sv
rtl/taint_execute.sv
rtl/taint_result.sv
rtl/taint_engine.sv
bench/taint_engine_tb.sv

// ==== Bender.yml ====
package:
  name: taint_engine

sources:
  - rtl/tnt_data_pkg.sv
  - rtl/tnt_cmd_pkg.sv
  - rtl/taint_decode.sv
  - rtl/taint_execute.sv
  - rtl/taint_result.sv
  - rtl/taint_engine.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/taint_engine_tb.sv

// ==== bench/taint_ref.svh ====
`ifndef TAINT_REF_SVH
`define TAINT_REF_SVH

// expected result taint, one function per propagation rule

function automatic logic [WORD_W-1:0] and_taint(input logic [WORD_W-1:0] a, b, at, bt);
    // a tainted bit leaks unless the other side holds a clean zero
    return (at & b) | (bt & a) | (at & bt);
endfunction

function automatic logic [WORD_W-1:0] or_taint(input logic [WORD_W-1:0] a, b, at, bt);
    return (at & ~b) | (bt & ~a) | (at & bt);
endfunction

// lowest and highest reachable sums differ wherever taint can ripple
function automatic logic [WORD_W-1:0] add_taint(input logic [WORD_W-1:0] a, b, at, bt);
    logic [WORD_W-1:0] low_sum;
    logic [WORD_W-1:0] high_sum;
    low_sum  = (a & ~at) + (b & ~bt);
    high_sum = (a | at) + (b | bt);
    return (low_sum ^ high_sum) | at | bt;
endfunction

function automatic logic [WORD_W-1:0] sub_taint(input logic [WORD_W-1:0] a, b, at, bt);
    logic [WORD_W-1:0] low_diff;
    logic [WORD_W-1:0] high_diff;
    low_diff  = (a & ~at) - (b & ~bt);
    high_diff = (a | at) - (b | bt);
    return (low_diff ^ high_diff) | at | bt;
endfunction

// an unknown shift amount smears the whole word
function automatic logic [WORD_W-1:0] shl_taint(input logic [WORD_W-1:0] b, at, bt);
    if (bt != '0) return '1;
    else return at << b[SHAMT_W-1:0];
endfunction

function automatic logic [WORD_W-1:0] shr_taint(input logic [WORD_W-1:0] b, at, bt);
    if (bt != '0) return '1;
    else return at >> b[SHAMT_W-1:0];
endfunction

function automatic logic [WORD_W-1:0] mux_taint(input logic [WORD_W-1:0] a, b, at, bt,
                                                input logic s, st);
    logic [WORD_W-1:0] picked;
    picked = s ? bt : at;
    if (st) picked = picked | (a ^ b);
    return picked;
endfunction

// known only when a clean one bit of a decides the result
function automatic logic [WORD_W-1:0] reduce_or_taint(input logic [WORD_W-1:0] a, at);
    logic [WORD_W-1:0] r;
    r = '0;
    r[0] = (at != '0) && ((a & ~at) == '0);
    return r;
endfunction

function automatic logic [WORD_W-1:0] predict_taint(input logic [OPC_W-1:0] op,
        input logic [WORD_W-1:0] a, b, at, bt, input logic s, st);
    case (op)
        OP_AND:    return and_taint(a, b, at, bt);
        OP_OR:     return or_taint(a, b, at, bt);
        OP_ADD:    return add_taint(a, b, at, bt);
        OP_SUB:    return sub_taint(a, b, at, bt);
        OP_SHL:    return shl_taint(b, at, bt);
        OP_SHR:    return shr_taint(b, at, bt);
        OP_MUX:    return mux_taint(a, b, at, bt, s, st);
        OP_RED_OR: return reduce_or_taint(a, at);
        default:   return '0;
    endcase
endfunction

`endif

// ==== bench/taint_engine_tb.sv ====
module taint_engine_tb import tnt_data_pkg::*, tnt_cmd_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    `include "taint_ref.svh"

    localparam int MAX_ROWS    = 48;
    localparam int RANDOM_ROWS = 24;

    logic                pos_clk;
    logic                pos_arst;
    logic                cmd_valid;
    cmd_u                cmd;
    logic [WORD_W-1:0]   a;
    logic [WORD_W-1:0]   b;
    logic [WORD_W-1:0]   a_taint;
    logic [WORD_W-1:0]   b_taint;
    logic                sel;
    logic                sel_taint;
    logic                res_valid;
    logic [WORD_W-1:0]   res_taint;
    logic [COUNT_W-1:0]  taint_count;

    // stimulus table, arg is the dst index or the live bitmap
    logic [OPC_W-1:0]    row_op [MAX_ROWS];
    logic [3:0]          row_arg [MAX_ROWS];
    logic [WORD_W-1:0]   row_a [MAX_ROWS];
    logic [WORD_W-1:0]   row_b [MAX_ROWS];
    logic [WORD_W-1:0]   row_at [MAX_ROWS];
    logic [WORD_W-1:0]   row_bt [MAX_ROWS];
    logic                row_sel [MAX_ROWS];
    logic                row_selt [MAX_ROWS];
    logic [WORD_W-1:0]   row_taint [MAX_ROWS];
    int                  row_cnt [MAX_ROWS];

    // shadow copy of the taint registers used while building the table
    logic [WORD_W-1:0]   model_regs [NUM_REGS];
    logic [NUM_REGS-1:0] model_live;
    int                  pipe_row [2];
    int                  last_cnt;
    int                  num_rows;
    int                  value_errors;
    int                  valid_errors;
    integer              seed;
    bit                  table_ready;

    taint_engine UUT (
        .pos_clk, .pos_arst, .cmd_valid, .cmd, .a, .b, .a_taint, .b_taint,
        .sel, .sel_taint, .res_valid, .res_taint, .taint_count
    );

    initial begin
        pos_clk = 1'b0;
        forever #20 pos_clk = ~pos_clk;
    end

    task automatic report_mismatch(input string name, input logic [WORD_W-1:0] expected,
                                   input logic [WORD_W-1:0] actual);
        $display("[FAIL] %0d ns %s expected %h got %h", $time, name, expected, actual);
        value_errors++;
    endtask

    function automatic int count_after(input logic [OPC_W-1:0] op, input logic [3:0] arg,
                                       input logic [WORD_W-1:0] exp_t);
        logic [WORD_W-1:0]   regs_next [NUM_REGS];
        logic [NUM_REGS-1:0] live_next;
        int                  n;
        regs_next = model_regs;
        live_next = model_live;
        n = 0;
        if (op <= OP_RED_OR) regs_next[arg[REG_IDX_W-1:0]] = exp_t;
        else if (op == OP_LIVE) live_next = arg;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (regs_next[i] != '0 && live_next[i]) n++;
        end
        return n;
    endfunction

    task automatic add_row(input logic [OPC_W-1:0] op, input logic [3:0] arg,
                           input logic [WORD_W-1:0] av, bv, at, bt, input logic s, st,
                           input logic [WORD_W-1:0] exp_t, input int exp_c);
        row_op[num_rows]    = op;
        row_arg[num_rows]   = arg;
        row_a[num_rows]     = av;
        row_b[num_rows]     = bv;
        row_at[num_rows]    = at;
        row_bt[num_rows]    = bt;
        row_sel[num_rows]   = s;
        row_selt[num_rows]  = st;
        row_taint[num_rows] = exp_t;
        row_cnt[num_rows]   = exp_c;
        if (op <= OP_RED_OR) model_regs[arg[REG_IDX_W-1:0]] = exp_t;
        else if (op == OP_LIVE) model_live = arg;
        num_rows++;
    endtask

    task automatic add_random_row();
        logic [OPC_W-1:0]  op;
        logic [3:0]        arg;
        logic [WORD_W-1:0] av;
        logic [WORD_W-1:0] bv;
        logic [WORD_W-1:0] at;
        logic [WORD_W-1:0] bt;
        logic [WORD_W-1:0] exp_t;
        logic [1:0]        sb;
        int                pick;
        pick = $unsigned($random(seed)) % 10;
        if (pick < 8) op = OPC_W'(pick);
        else if (pick == 8) op = OP_LIVE;
        else op = OPC_W'(8 + $unsigned($random(seed)) % 7);
        arg = $random(seed);
        av  = $random(seed);
        bv  = $random(seed);
        // sparse taint, and a clean b half the time so shifts move bits
        at  = $random(seed) & $random(seed);
        bt  = ($random(seed) % 2 == 0) ? '0 : $random(seed) & $random(seed);
        sb  = $random(seed);
        exp_t = (op <= OP_RED_OR) ? predict_taint(op, av, bv, at, bt, sb[0], sb[1]) : '0;
        add_row(op, arg, av, bv, at, bt, sb[0], sb[1], exp_t, count_after(op, arg, exp_t));
    endtask

    task automatic build_table();
        num_rows   = 0;
        model_live = '1;
        for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
        // expected taint by hand, count after the write or bitmap change
        add_row(OP_AND, 4'd0, 16'h00FF, 16'h0F0F, 16'h0003, 16'h0100, 0, 0, 16'h0003, 1);
        add_row(OP_OR, 4'd1, 16'h00F0, 16'h000F, 16'h0011, 16'h0022, 0, 0, 16'h0012, 2);
        add_row(OP_RED_OR, 4'd2, 16'h0030, 16'h0000, 16'h0010, 16'h0000, 0, 0, 16'h0000, 2);
        add_row(OP_RED_OR, 4'd2, 16'h0030, 16'h0000, 16'h00F0, 16'h0000, 0, 0, 16'h0001, 3);
        add_row(OP_ADD, 4'd3, 16'h00FF, 16'h0001, 16'h0001, 16'h0000, 0, 0, 16'h01FF, 4);
        add_row(OP_SUB, 4'd3, 16'h0000, 16'h0001, 16'h0000, 16'h0001, 0, 0, 16'hFFFF, 4);
        add_row(OP_SHL, 4'd0, 16'h0000, 16'h0004, 16'h0081, 16'h0000, 0, 0, 16'h0810, 4);
        add_row(OP_SHR, 4'd1, 16'h0000, 16'h0013, 16'h8100, 16'h0000, 0, 0, 16'h1020, 4);
        add_row(OP_SHL, 4'd2, 16'h0000, 16'h0002, 16'h0001, 16'h0004, 0, 0, 16'hFFFF, 4);
        add_row(OP_MUX, 4'd0, 16'h1234, 16'h4321, 16'h00AA, 16'h0055, 1, 0, 16'h0055, 4);
        add_row(OP_MUX, 4'd1, 16'h0F00, 16'h00F0, 16'h0001, 16'h0002, 0, 1, 16'h0FF1, 4);
        add_row(OP_LIVE, 4'b0101, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 0, 0, 16'h0000, 2);
        add_row(OP_AND, 4'd0, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 0, 0, 16'h0000, 1);
        add_row(4'd9, 4'd3, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 1, 1, 16'h0000, 1);
        add_row(OP_LIVE, 4'b0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 0, 0, 16'h0000, 0);
        add_row(OP_LIVE, 4'b1111, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 0, 0, 16'h0000, 3);
        add_row(OP_OR, 4'd1, 16'h0001, 16'h0002, 16'h0000, 16'h0000, 0, 0, 16'h0000, 2);
        repeat (RANDOM_ROWS) add_random_row();
    endtask

    task automatic drive_idle();
        cmd_valid = 1'b0;
        cmd       = '0;
        a         = '0;
        b         = '0;
        a_taint   = '0;
        b_taint   = '0;
        sel       = 1'b0;
        sel_taint = 1'b0;
    endtask

    task automatic drive_row(input int i);
        cmd_valid = 1'b1;
        cmd = '0;
        cmd.alu.opcode = row_op[i];
        if (row_op[i] == OP_LIVE) cmd.live.mask = row_arg[i];
        else cmd.alu.dst = row_arg[i][REG_IDX_W-1:0];
        a         = row_a[i];
        b         = row_b[i];
        a_taint   = row_at[i];
        b_taint   = row_bt[i];
        sel       = row_sel[i];
        sel_taint = row_selt[i];
    endtask

    // the row driven two falling edges ago is due now
    task automatic check_outputs();
        int r;
        r = pipe_row[1];
        if (r >= 0 && row_op[r] <= OP_RED_OR) begin
            if (res_valid !== 1'b1) begin
                $display("error at %0d ns: row %0d gave no res_valid", $time, r);
                valid_errors++;
            end else if (res_taint !== row_taint[r]) begin
                report_mismatch("res_taint", row_taint[r], res_taint);
            end
        end else if (res_valid !== 1'b0) begin
            $display("error at %0d ns: res_valid high with no compute command due", $time);
            valid_errors++;
        end
        if (r >= 0) last_cnt = row_cnt[r];
        if (taint_count !== last_cnt) report_mismatch("taint_count", last_cnt, taint_count);
    endtask

    task automatic clock_step(input int i);
        @(negedge pos_clk);
        check_outputs();
        pipe_row[1] = pipe_row[0];
        pipe_row[0] = i;
        if (i >= 0) drive_row(i);
        else drive_idle();
    endtask

    task automatic hold_reset();
        repeat (3) begin
            @(negedge pos_clk);
            if (res_valid !== 1'b0) report_mismatch("res_valid", '0, res_valid);
            if (res_taint !== '0) report_mismatch("res_taint", '0, res_taint);
            if (taint_count !== '0) report_mismatch("taint_count", '0, taint_count);
        end
        pos_arst    = 1'b0;
        pipe_row[0] = -1;
        pipe_row[1] = -1;
        last_cnt    = 0;
    endtask

    // pass one spends two cycles per row, pass two one, plus resets and flushes
    initial begin
        wait (table_ready);
        #((num_rows * 3 + 20) * 40);
        $display("watchdog expired at %0d ns before the run completed", $time);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        pos_arst     = 1'b1;
        seed         = 32'h2dd3a6ce;
        value_errors = 0;
        valid_errors = 0;
        drive_idle();
        build_table();
        table_ready = 1'b1;
        hold_reset();
        // one row at a time, each result drains before the next command
        for (int i = 0; i < num_rows; i++) begin
            clock_step(i);
            clock_step(-1);
        end
        clock_step(-1);
        clock_step(-1);
        pos_arst = 1'b1;
        hold_reset();
        // back to back, a command on every cycle
        for (int i = 0; i < num_rows; i++) clock_step(i);
        clock_step(-1);
        clock_step(-1);
        $display("rows %0d, value errors %0d, valid errors %0d",
                 num_rows, value_errors, valid_errors);
        if (value_errors + valid_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== rtl/taint_engine.sv ====
module taint_engine import tnt_data_pkg::*, tnt_cmd_pkg::*; (
    input  logic               pos_clk,
    input  logic               pos_arst,
    input  logic               cmd_valid,
    input  cmd_u               cmd,
    input  logic [WORD_W-1:0]  a,
    input  logic [WORD_W-1:0]  b,
    input  logic [WORD_W-1:0]  a_taint,
    input  logic [WORD_W-1:0]  b_taint,
    input  logic               sel,
    input  logic               sel_taint,
    output logic               res_valid,
    output logic [WORD_W-1:0]  res_taint,
    output logic [COUNT_W-1:0] taint_count
);

    // stage 1 registered command and operands
    logic                 op_valid;
    logic [OPC_W-1:0]     op_code;
    logic [REG_IDX_W-1:0] op_dst;
    logic [WORD_W-1:0]    op_a;
    logic [WORD_W-1:0]    op_b;
    logic [WORD_W-1:0]    op_at;
    logic [WORD_W-1:0]    op_bt;
    logic                 op_sel;
    logic                 op_selt;
    logic                 live_valid;
    logic [NUM_REGS-1:0]  live_mask;

    logic [WORD_W-1:0]    exe_taint;

    taint_decode u_decode (
        .pos_clk, .pos_arst, .cmd_valid, .cmd,
        .a, .b, .a_taint, .b_taint, .sel, .sel_taint,
        .op_valid, .op_code, .op_dst, .op_a, .op_b, .op_at, .op_bt,
        .op_sel, .op_selt, .live_valid, .live_mask
    );

    // taint rules, combinational between the two register stages
    taint_execute u_execute (
        .op_code, .op_a, .op_b, .op_at, .op_bt, .op_sel, .op_selt,
        .exe_taint
    );

    taint_result u_result (
        .pos_clk, .pos_arst, .op_valid, .op_dst, .exe_taint,
        .live_valid, .live_mask,
        .res_valid, .res_taint, .taint_count
    );

endmodule

// ==== rtl/taint_result.sv ====
module taint_result import tnt_data_pkg::*; (
    input  logic                 pos_clk,
    input  logic                 pos_arst,
    input  logic                 op_valid,
    input  logic [REG_IDX_W-1:0] op_dst,
    input  logic [WORD_W-1:0]    exe_taint,
    input  logic                 live_valid,
    input  logic [NUM_REGS-1:0]  live_mask,
    output logic                 res_valid,
    output logic [WORD_W-1:0]    res_taint,
    output logic [COUNT_W-1:0]   taint_count
);

    // shadow taint registers and their liveness bits
    logic [WORD_W-1:0]   taint_regs [NUM_REGS];
    logic [NUM_REGS-1:0] live_bits;
    logic [NUM_REGS-1:0] reg_hot;

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            res_valid <= 1'b0;
            res_taint <= '0;
        end else begin
            res_valid <= op_valid;
            if (op_valid) begin
                res_taint <= exe_taint;
            end
        end
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                taint_regs[i] <= '0;
            end
        end else if (op_valid) begin
            taint_regs[op_dst] <= exe_taint;
        end
    end

    // every register counts as live until a bitmap says otherwise
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            live_bits <= '1;
        end else if (live_valid) begin
            live_bits <= live_mask;
        end
    end

    // a register counts when it holds taint and is live
    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            reg_hot[i] = (|taint_regs[i]) & live_bits[i];
        end
    end

    always_comb begin
        taint_count = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            taint_count = taint_count + COUNT_W'(reg_hot[i]);
        end
    end

    // a compute result and a bitmap load never arrive in the same cycle
    assert property (@(posedge pos_clk) disable iff (pos_arst)
        !(op_valid && live_valid));

endmodule

// ==== rtl/taint_execute.sv ====
module taint_execute import tnt_data_pkg::*, tnt_cmd_pkg::*; (
    input  logic [OPC_W-1:0]  op_code,
    input  logic [WORD_W-1:0] op_a,
    input  logic [WORD_W-1:0] op_b,
    input  logic [WORD_W-1:0] op_at,
    input  logic [WORD_W-1:0] op_bt,
    input  logic              op_sel,
    input  logic              op_selt,
    output logic [WORD_W-1:0] exe_taint
);

    // untainted and high values of each operand
    logic [WORD_W-1:0]  a_low;
    logic [WORD_W-1:0]  b_low;
    logic [WORD_W-1:0]  a_high;
    logic [WORD_W-1:0]  b_high;
    logic [WORD_W-1:0]  sum_diff;
    logic [WORD_W-1:0]  sub_diff;
    logic [SHAMT_W-1:0] shamt;
    logic               b_tainted;
    logic               red_taint;

    assign a_low  = op_a & ~op_at;
    assign b_low  = op_b & ~op_bt;
    assign a_high = op_a | op_at;
    assign b_high = op_b | op_bt;

    // bits where the two extremes disagree can be flipped by taint
    assign sum_diff = (a_low + b_low) ^ (a_high + b_high);
    assign sub_diff = (a_low - b_low) ^ (a_high - b_high);

    assign shamt     = op_b[SHAMT_W-1:0];
    assign b_tainted = |op_bt;

    // reduce result is known once some clean bit of a is set
    assign red_taint = (|op_at) && !(|a_low);

    always_comb begin
        case (op_code)
            OP_AND: begin
                exe_taint = (op_at & op_b) | (op_bt & op_a) | (op_at & op_bt);
            end
            OP_OR: begin
                exe_taint = (op_at & ~op_b) | (op_bt & ~op_a) | (op_at & op_bt);
            end
            OP_ADD: begin
                exe_taint = sum_diff | op_at | op_bt;
            end
            OP_SUB: begin
                exe_taint = sub_diff | op_at | op_bt;
            end
            OP_SHL: begin
                exe_taint = b_tainted ? {WORD_W{1'b1}} : op_at << shamt;
            end
            OP_SHR: begin
                exe_taint = b_tainted ? {WORD_W{1'b1}} : op_at >> shamt;
            end
            OP_MUX: begin
                // a tainted select leaks every bit where the inputs differ
                exe_taint = (op_sel ? op_bt : op_at) | (op_selt ? op_a ^ op_b : '0);
            end
            OP_RED_OR: begin
                exe_taint = {{(WORD_W-1){1'b0}}, red_taint};
            end
            default: begin
                exe_taint = '0;
            end
        endcase
    end

endmodule

// ==== rtl/taint_decode.sv ====
module taint_decode import tnt_data_pkg::*, tnt_cmd_pkg::*; (
    input  logic                 pos_clk,
    input  logic                 pos_arst,
    input  logic                 cmd_valid,
    input  cmd_u                 cmd,
    input  logic [WORD_W-1:0]    a,
    input  logic [WORD_W-1:0]    b,
    input  logic [WORD_W-1:0]    a_taint,
    input  logic [WORD_W-1:0]    b_taint,
    input  logic                 sel,
    input  logic                 sel_taint,
    output logic                 op_valid,
    output logic [OPC_W-1:0]     op_code,
    output logic [REG_IDX_W-1:0] op_dst,
    output logic [WORD_W-1:0]    op_a,
    output logic [WORD_W-1:0]    op_b,
    output logic [WORD_W-1:0]    op_at,
    output logic [WORD_W-1:0]    op_bt,
    output logic                 op_sel,
    output logic                 op_selt,
    output logic                 live_valid,
    output logic [NUM_REGS-1:0]  live_mask
);

    logic is_alu;
    logic is_live;

    // opcode sits in the same place in both views
    assign is_alu  = cmd_valid && (cmd.alu.opcode <= OP_RED_OR);
    assign is_live = cmd_valid && (cmd.alu.opcode == OP_LIVE);

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            op_valid   <= 1'b0;
            live_valid <= 1'b0;
        end else begin
            op_valid   <= is_alu;
            live_valid <= is_live;
        end
    end

    // operand capture only on a legal compute command
    always_ff @(posedge pos_clk) begin
        if (is_alu) begin
            op_code <= cmd.alu.opcode;
            op_dst  <= cmd.alu.dst;
            op_a    <= a;
            op_b    <= b;
            op_at   <= a_taint;
            op_bt   <= b_taint;
            op_sel  <= sel;
            op_selt <= sel_taint;
        end
        if (is_live) begin
            live_mask <= cmd.live.mask;
        end
    end

    assert property (@(posedge pos_clk) disable iff (pos_arst) cmd_valid |-> !$isunknown(cmd));

endmodule

// ==== rtl/tnt_cmd_pkg.sv ====
package tnt_cmd_pkg;

    import tnt_data_pkg::*;

    // command word layout, opcode always in the top bits
    localparam int CMD_W = 16;
    localparam int OPC_W = 4;

    // compute opcodes
    localparam logic [OPC_W-1:0] OP_AND    = 4'd0;
    localparam logic [OPC_W-1:0] OP_OR     = 4'd1;
    localparam logic [OPC_W-1:0] OP_ADD    = 4'd2;
    localparam logic [OPC_W-1:0] OP_SUB    = 4'd3;
    localparam logic [OPC_W-1:0] OP_SHL    = 4'd4;
    localparam logic [OPC_W-1:0] OP_SHR    = 4'd5;
    localparam logic [OPC_W-1:0] OP_MUX    = 4'd6;
    localparam logic [OPC_W-1:0] OP_RED_OR = 4'd7;

    // liveness bitmap load, 8 to 14 are illegal
    localparam logic [OPC_W-1:0] OP_LIVE   = 4'd15;

    // compute view, destination register index below the opcode
    typedef struct packed {
        logic [OPC_W-1:0]                  opcode;
        logic [REG_IDX_W-1:0]              dst;
        logic [CMD_W-OPC_W-REG_IDX_W-1:0]  spare;
    } cmd_alu_t;

    // liveness view, one live bit per shadow register
    typedef struct packed {
        logic [OPC_W-1:0]                  opcode;
        logic [NUM_REGS-1:0]               mask;
        logic [CMD_W-OPC_W-NUM_REGS-1:0]   spare;
    } cmd_live_t;

    // the opcode picks which view holds meaning
    typedef union packed {
        cmd_alu_t  alu;
        cmd_live_t live;
    } cmd_u;

endpackage

// ==== rtl/tnt_data_pkg.sv ====
package tnt_data_pkg;

    // operand values and their taint masks share one width
    localparam int WORD_W = 16;

    // shadow taint registers behind the result stage
    localparam int NUM_REGS = 4;

    // index into the shadow registers
    localparam int REG_IDX_W = 2;

    // live taint count, holds 0 to NUM_REGS
    localparam int COUNT_W = 3;

    // low bits of operand b that form the shift amount
    localparam int SHAMT_W = 4;

endpackage
